//--- compile.f
+incdir+verification
source/cpu_isa_pkg.sv
source/cpu_pipe_pkg.sv
source/fetch_stage.sv
source/pipeline_control.sv
source/register_file.sv
source/alu.sv
source/execute_stage.sv
source/mem_writeback.sv
source/cpu_core.sv
verification/cpu_tb.sv

//--- source/alu.sv
module alu (
    input  cpu_isa_pkg::opcode_e  opcode,
    input  cpu_isa_pkg::word_t    rd_val,
    input  cpu_isa_pkg::word_t    rs_val,
    input  cpu_isa_pkg::word_t    rt_val,
    input  cpu_isa_pkg::literal_t literal,
    output cpu_isa_pkg::word_t    result
);
    cpu_isa_pkg::word_t lit_zx; // zero-extended L
    cpu_isa_pkg::word_t lit_sx; // sign-extended L, for addresses

    assign lit_zx = {52'd0, literal};
    assign lit_sx = {{52{literal[11]}}, literal};

    always_comb begin
        case (opcode)
            cpu_isa_pkg::op_add:    result = rs_val + rt_val;
            cpu_isa_pkg::op_addi:   result = rd_val + lit_zx;
            cpu_isa_pkg::op_sub:    result = rs_val - rt_val;
            cpu_isa_pkg::op_subi:   result = rd_val - lit_zx;
            cpu_isa_pkg::op_and:    result = rs_val & rt_val;
            cpu_isa_pkg::op_or:     result = rs_val | rt_val;
            cpu_isa_pkg::op_xor:    result = rs_val ^ rt_val;
            cpu_isa_pkg::op_not:    result = ~rs_val; // rt unused
            cpu_isa_pkg::op_shftr:  result = rs_val >> rt_val;
            cpu_isa_pkg::op_shftri: result = rd_val >> lit_zx;
            cpu_isa_pkg::op_shftl:  result = rs_val << rt_val;
            cpu_isa_pkg::op_shftli: result = rd_val << lit_zx;
            cpu_isa_pkg::op_mov_rs: result = rs_val;
            cpu_isa_pkg::op_mov_l:  result = {rd_val[63:12], literal}; // low 12 bits only
            cpu_isa_pkg::op_load:   result = rs_val + lit_sx; // load address
            cpu_isa_pkg::op_store:  result = rd_val + lit_sx; // store address
            default:                result = '0;
        endcase
    end

endmodule

//--- source/cpu_core.sv
module cpu_core (
    input  logic                  clk,
    input  logic                  reset,
    input  cpu_isa_pkg::instr_t   instr,
    input  cpu_isa_pkg::word_t    load_data,
    output cpu_isa_pkg::addr_t    fetch_addr,
    output cpu_isa_pkg::addr_t    data_addr,
    output logic                  store_we,
    output cpu_isa_pkg::word_t    store_data,
    output logic                  retire_we,
    output cpu_isa_pkg::reg_idx_t retire_dest,
    output cpu_isa_pkg::word_t    retire_data,
    output logic                  hlt
);
    cpu_isa_pkg::addr_t       ifid_pc, branch_target;
    cpu_isa_pkg::instr_t      ifid_instr;
    cpu_isa_pkg::reg_idx_t    rd_idx, rs_idx, rt_idx;
    cpu_isa_pkg::word_t       rd_val, rs_val, rt_val;
    logic                     stall, redirect, halt_seen, idex_bubble;
    cpu_pipe_pkg::idex_t      idex_in;
    cpu_pipe_pkg::fwd_ctrl_t  fwd;
    cpu_pipe_pkg::dest_info_t idex_dest_info;
    cpu_pipe_pkg::exmem_t     exmem;
    cpu_pipe_pkg::memwb_t     memwb;
    cpu_pipe_pkg::wb_t        wb;

    // retire port mirrors the writeback channel
    assign retire_we   = wb.we;
    assign retire_dest = wb.dest;
    assign retire_data = wb.data;

    fetch_stage i_fetch (
        .clk, .reset, .stall, .redirect, .branch_target, .halt_seen, .instr,
        .fetch_addr, .ifid_pc, .ifid_instr
    );

    pipeline_control i_ctrl (
        .clk, .reset, .ifid_pc, .ifid_instr, .rd_val, .rs_val, .rt_val,
        .idex_dest_info, .exmem, .memwb, .rd_idx, .rs_idx, .rt_idx, .stall,
        .redirect, .branch_target, .halt_seen, .idex_in, .idex_bubble, .fwd
    );

    register_file i_regs (
        .clk, .reset, .wb, .rd_idx, .rs_idx, .rt_idx, .rd_val, .rs_val, .rt_val
    );

    execute_stage i_exec (
        .clk, .reset, .idex_in, .idex_bubble, .fwd, .wb, .idex_dest_info, .exmem
    );

    mem_writeback i_memwb (
        .clk, .reset, .exmem, .load_data, .data_addr, .store_we, .store_data,
        .memwb, .wb, .hlt
    );

endmodule

//--- source/cpu_isa_pkg.sv
package cpu_isa_pkg;

    typedef logic [63:0] word_t;    // register value
    typedef logic [31:0] addr_t;    // byte address
    typedef logic [31:0] instr_t;   // instruction word
    typedef logic [4:0]  reg_idx_t; // register number
    typedef logic [11:0] literal_t; // L field

    // opcode field, bits 31:27
    typedef enum logic [4:0] {
        op_and    = 5'h00,
        op_or     = 5'h01,
        op_xor    = 5'h02,
        op_not    = 5'h03,
        op_shftr  = 5'h04,
        op_shftri = 5'h05,
        op_shftl  = 5'h06,
        op_shftli = 5'h07,
        op_br     = 5'h08, // pc = rd
        op_brr_rd = 5'h09, // pc += rd
        op_brr_l  = 5'h0a, // pc += sext(L)
        op_brnz   = 5'h0b,
        op_brgt   = 5'h0e,
        op_halt   = 5'h0f,
        op_load   = 5'h10, // mov rd, (rs)(L)
        op_mov_rs = 5'h11,
        op_mov_l  = 5'h12,
        op_store  = 5'h13, // mov (rd)(L), rs
        op_add    = 5'h18,
        op_addi   = 5'h19,
        op_sub    = 5'h1a,
        op_subi   = 5'h1b
    } opcode_e;

    localparam addr_t pc_reset_addr     = 32'h0000_2000; // first fetch
    localparam word_t stack_reset_value = 64'h8_0000;    // r31 after reset
    localparam addr_t instr_bytes       = 32'd4;

    // mov r0, r0 with all other fields zero
    localparam instr_t nop_instr = {op_mov_rs, 27'd0};

endpackage

//--- source/cpu_pipe_pkg.sv
package cpu_pipe_pkg;

    // control bits that travel down the pipe
    typedef struct packed {
        logic reg_write;
        logic mem_read;
        logic mem_write;
        logic mem_to_reg; // wb picks load data
        logic halt;
    } ctrl_t;

    // operand source in EX
    typedef enum logic [1:0] {
        from_regfile = 2'd0,
        from_exmem   = 2'd1,
        from_memwb   = 2'd2
    } fwd_sel_e;

    typedef struct packed {
        fwd_sel_e rd;
        fwd_sel_e rs;
        fwd_sel_e rt;
    } fwd_ctrl_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        cpu_isa_pkg::opcode_e  opcode;
        cpu_isa_pkg::reg_idx_t rd;
        cpu_isa_pkg::reg_idx_t rs;
        cpu_isa_pkg::reg_idx_t rt;
        cpu_isa_pkg::literal_t L;
        cpu_isa_pkg::word_t    rd_val;
        cpu_isa_pkg::word_t    rs_val;
        cpu_isa_pkg::word_t    rt_val;
    } idex_t;

    // what decode needs to know about the ID/EX occupant
    typedef struct packed {
        ctrl_t                 ctrl;
        cpu_isa_pkg::reg_idx_t dest;
    } dest_info_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        cpu_isa_pkg::word_t    alu_result; // also the data address
        cpu_isa_pkg::word_t    store_data;
        cpu_isa_pkg::reg_idx_t dest;
    } exmem_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        cpu_isa_pkg::word_t    mem_data;
        cpu_isa_pkg::word_t    alu_result;
        cpu_isa_pkg::reg_idx_t dest;
    } memwb_t;

    // writeback channel
    typedef struct packed {
        logic                  we;
        cpu_isa_pkg::reg_idx_t dest;
        cpu_isa_pkg::word_t    data;
    } wb_t;

endpackage

//--- source/execute_stage.sv
module execute_stage (
    input  logic                     clk,
    input  logic                     reset,
    input  cpu_pipe_pkg::idex_t      idex_in,
    input  logic                     idex_bubble,
    input  cpu_pipe_pkg::fwd_ctrl_t  fwd,
    input  cpu_pipe_pkg::wb_t        wb,
    output cpu_pipe_pkg::dest_info_t idex_dest_info,
    output cpu_pipe_pkg::exmem_t     exmem
);
    cpu_pipe_pkg::idex_t idex;
    cpu_isa_pkg::word_t  rd_op, rs_op, rt_op; // forwarded operands
    cpu_isa_pkg::word_t  alu_result;

    function automatic cpu_isa_pkg::word_t operand(input cpu_pipe_pkg::fwd_sel_e sel,
                                                   input cpu_isa_pkg::word_t    rf_val,
                                                   input cpu_isa_pkg::word_t    ex_val,
                                                   input cpu_isa_pkg::word_t    wb_val);
        case (sel)
            cpu_pipe_pkg::from_exmem: operand = ex_val;
            cpu_pipe_pkg::from_memwb: operand = wb_val;
            default:                  operand = rf_val;
        endcase
    endfunction

    // ID/EX register
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            idex <= '0;
        else if (idex_bubble)
            idex <= '0; // ctrl all zero, nothing happens downstream
        else
            idex <= idex_in;
    end

    assign idex_dest_info = '{ctrl: idex.ctrl, dest: idex.rd};

    assign rd_op = operand(fwd.rd, idex.rd_val, exmem.alu_result, wb.data);
    assign rs_op = operand(fwd.rs, idex.rs_val, exmem.alu_result, wb.data);
    assign rt_op = operand(fwd.rt, idex.rt_val, exmem.alu_result, wb.data);

    alu i_alu (
        .opcode  (idex.opcode),
        .rd_val  (rd_op),
        .rs_val  (rs_op),
        .rt_val  (rt_op),
        .literal (idex.L),
        .result  (alu_result)
    );

    // EX/MEM register
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            exmem <= '0;
        else
            exmem <= '{ctrl: idex.ctrl, alu_result: alu_result,
                       store_data: rs_op, dest: idex.rd}; // store data is rs
    end

endmodule

//--- source/fetch_stage.sv
module fetch_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,
    input  logic                redirect,
    input  cpu_isa_pkg::addr_t  branch_target,
    input  logic                halt_seen,
    input  cpu_isa_pkg::instr_t instr,
    output cpu_isa_pkg::addr_t  fetch_addr,
    output cpu_isa_pkg::addr_t  ifid_pc,
    output cpu_isa_pkg::instr_t ifid_instr
);
    cpu_isa_pkg::addr_t pc;

    assign fetch_addr = pc; // instr comes back this cycle

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= cpu_isa_pkg::pc_reset_addr;
        end else if (redirect) begin
            pc <= branch_target; // taken branch in decode
        end else if (!stall && !halt_seen) begin
            pc <= pc + cpu_isa_pkg::instr_bytes;
        end
    end

    // IF/ID register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ifid_pc    <= '0;
            ifid_instr <= cpu_isa_pkg::nop_instr;
        end else if (redirect || halt_seen) begin
            ifid_instr <= cpu_isa_pkg::nop_instr; // squash wrong path
        end else if (!stall) begin
            ifid_pc    <= pc;
            ifid_instr <= instr;
        end
    end

endmodule

//--- source/mem_writeback.sv
module mem_writeback (
    input  logic                 clk,
    input  logic                 reset,
    input  cpu_pipe_pkg::exmem_t exmem,
    input  cpu_isa_pkg::word_t   load_data,
    output cpu_isa_pkg::addr_t   data_addr,
    output logic                 store_we,
    output cpu_isa_pkg::word_t   store_data,
    output cpu_pipe_pkg::memwb_t memwb,
    output cpu_pipe_pkg::wb_t    wb,
    output logic                 hlt
);
    logic hlt_q; // halt already retired

    // data port, load data returns in the same cycle
    assign data_addr  = exmem.alu_result[31:0];
    assign store_we   = exmem.ctrl.mem_write;
    assign store_data = exmem.store_data;

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            memwb <= '0;
        else
            memwb <= '{ctrl: exmem.ctrl, mem_data: load_data,
                       alu_result: exmem.alu_result, dest: exmem.dest};
    end

    assign wb.we   = memwb.ctrl.reg_write;
    assign wb.dest = memwb.dest;
    assign wb.data = memwb.ctrl.mem_to_reg ? memwb.mem_data : memwb.alu_result;

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            hlt_q <= 1'b0;
        else if (memwb.ctrl.halt)
            hlt_q <= 1'b1;
    end

    assign hlt = hlt_q || memwb.ctrl.halt; // up from the halt's wb cycle

endmodule

//--- source/pipeline_control.sv
module pipeline_control (
    input  logic                     clk,
    input  logic                     reset,
    input  cpu_isa_pkg::addr_t       ifid_pc,
    input  cpu_isa_pkg::instr_t      ifid_instr,
    input  cpu_isa_pkg::word_t       rd_val,
    input  cpu_isa_pkg::word_t       rs_val,
    input  cpu_isa_pkg::word_t       rt_val,
    input  cpu_pipe_pkg::dest_info_t idex_dest_info,
    input  cpu_pipe_pkg::exmem_t     exmem,
    input  cpu_pipe_pkg::memwb_t     memwb,
    output cpu_isa_pkg::reg_idx_t    rd_idx,
    output cpu_isa_pkg::reg_idx_t    rs_idx,
    output cpu_isa_pkg::reg_idx_t    rt_idx,
    output logic                     stall,
    output logic                     redirect,
    output cpu_isa_pkg::addr_t       branch_target,
    output logic                     halt_seen,
    output cpu_pipe_pkg::idex_t      idex_in,
    output logic                     idex_bubble,
    output cpu_pipe_pkg::fwd_ctrl_t  fwd
);
    cpu_isa_pkg::opcode_e   opcode;
    cpu_isa_pkg::literal_t  literal;
    cpu_pipe_pkg::ctrl_t    ctrl;
    logic                   taken;
    logic                   uses_rd, uses_rs, uses_rt; // branch sources
    logic                   ex_hit, mem_hit;
    logic                   load_use, branch_wait;
    cpu_isa_pkg::reg_idx_t  ex_rs, ex_rt; // sources of the ID/EX occupant

    // EX/MEM wins over MEM/WB
    function automatic cpu_pipe_pkg::fwd_sel_e pick(input cpu_isa_pkg::reg_idx_t src,
                                                     input cpu_pipe_pkg::exmem_t  em,
                                                     input cpu_pipe_pkg::memwb_t  mw);
        if (em.ctrl.reg_write && em.dest == src)
            pick = cpu_pipe_pkg::from_exmem;
        else if (mw.ctrl.reg_write && mw.dest == src)
            pick = cpu_pipe_pkg::from_memwb;
        else
            pick = cpu_pipe_pkg::from_regfile;
    endfunction

    assign opcode  = cpu_isa_pkg::opcode_e'(ifid_instr[31:27]);
    assign rd_idx  = ifid_instr[26:22];
    assign rs_idx  = ifid_instr[21:17];
    assign rt_idx  = ifid_instr[16:12];
    assign literal = ifid_instr[11:0];

    always_comb begin
        ctrl = '0; // unknown opcodes and branches do nothing downstream
        case (opcode)
            cpu_isa_pkg::op_add, cpu_isa_pkg::op_addi, cpu_isa_pkg::op_sub,
            cpu_isa_pkg::op_subi, cpu_isa_pkg::op_and, cpu_isa_pkg::op_or,
            cpu_isa_pkg::op_xor, cpu_isa_pkg::op_not, cpu_isa_pkg::op_shftr,
            cpu_isa_pkg::op_shftri, cpu_isa_pkg::op_shftl, cpu_isa_pkg::op_shftli,
            cpu_isa_pkg::op_mov_l:
                ctrl.reg_write = 1'b1;
            cpu_isa_pkg::op_mov_rs:
                ctrl.reg_write = (ifid_instr != cpu_isa_pkg::nop_instr); // squash slot
            cpu_isa_pkg::op_load: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            cpu_isa_pkg::op_store: ctrl.mem_write = 1'b1;
            cpu_isa_pkg::op_halt:  ctrl.halt      = 1'b1;
            default: ;
        endcase
    end

    // branches resolve here on register file values
    always_comb begin
        taken         = 1'b0;
        uses_rd       = 1'b0;
        uses_rs       = 1'b0;
        uses_rt       = 1'b0;
        branch_target = rd_val[31:0];
        case (opcode)
            cpu_isa_pkg::op_br: begin
                uses_rd = 1'b1;
                taken   = 1'b1;
            end
            cpu_isa_pkg::op_brr_rd: begin
                uses_rd       = 1'b1;
                taken         = 1'b1;
                branch_target = ifid_pc + rd_val[31:0];
            end
            cpu_isa_pkg::op_brr_l: begin
                taken         = 1'b1;
                branch_target = ifid_pc + {{20{literal[11]}}, literal};
            end
            cpu_isa_pkg::op_brnz: begin
                uses_rd = 1'b1;
                uses_rs = 1'b1;
                taken   = (rs_val != '0);
            end
            cpu_isa_pkg::op_brgt: begin
                uses_rd = 1'b1;
                uses_rs = 1'b1;
                uses_rt = 1'b1;
                taken   = ($signed(rs_val) > $signed(rt_val));
            end
            default: ;
        endcase
    end

    // no wait on MEM/WB as the register file reads write-first
    assign ex_hit  = (uses_rd && idex_dest_info.dest == rd_idx) ||
                     (uses_rs && idex_dest_info.dest == rs_idx) ||
                     (uses_rt && idex_dest_info.dest == rt_idx);
    assign mem_hit = (uses_rd && exmem.dest == rd_idx) ||
                     (uses_rs && exmem.dest == rs_idx) ||
                     (uses_rt && exmem.dest == rt_idx);
    assign branch_wait = (idex_dest_info.ctrl.reg_write && ex_hit) ||
                         (exmem.ctrl.reg_write && mem_hit);

    assign load_use = idex_dest_info.ctrl.mem_read &&
                      (idex_dest_info.dest == rd_idx || idex_dest_info.dest == rs_idx ||
                       idex_dest_info.dest == rt_idx);

    assign stall       = load_use || branch_wait;
    assign redirect    = taken && !stall && !halt_seen; // fetch stays frozen after halt
    assign idex_bubble = stall || redirect || halt_seen;

    assign idex_in = '{ctrl: ctrl, opcode: opcode, rd: rd_idx, rs: rs_idx, rt: rt_idx,
                       L: literal, rd_val: rd_val, rs_val: rs_val, rt_val: rt_val};

    assign fwd.rd = pick(idex_dest_info.dest, exmem, memwb);
    assign fwd.rs = pick(ex_rs, exmem, memwb);
    assign fwd.rt = pick(ex_rt, exmem, memwb);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            halt_seen <= 1'b0;
            ex_rs     <= '0;
            ex_rt     <= '0;
        end else begin
            if (ctrl.halt && !stall)
                halt_seen <= 1'b1; // stays until reset
            if (idex_bubble) begin
                ex_rs <= '0;
                ex_rt <= '0;
            end else begin
                ex_rs <= rs_idx; // follows ID/EX
                ex_rt <= rt_idx;
            end
        end
    end

endmodule

//--- source/register_file.sv
module register_file (
    input  logic                  clk,
    input  logic                  reset,
    input  cpu_pipe_pkg::wb_t     wb,
    input  cpu_isa_pkg::reg_idx_t rd_idx,
    input  cpu_isa_pkg::reg_idx_t rs_idx,
    input  cpu_isa_pkg::reg_idx_t rt_idx,
    output cpu_isa_pkg::word_t    rd_val,
    output cpu_isa_pkg::word_t    rs_val,
    output cpu_isa_pkg::word_t    rt_val
);
    cpu_isa_pkg::word_t regs [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 31; i++)
                regs[i] <= '0;
            regs[31] <= cpu_isa_pkg::stack_reset_value; // stack pointer
        end else if (wb.we) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // write-first, a same-cycle write shows up on the read ports
    assign rd_val = (wb.we && wb.dest == rd_idx) ? wb.data : regs[rd_idx];
    assign rs_val = (wb.we && wb.dest == rs_idx) ? wb.data : regs[rs_idx];
    assign rt_val = (wb.we && wb.dest == rt_idx) ? wb.data : regs[rt_idx];

endmodule

//--- verification/cpu_model.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

    cpu_isa_pkg::instr_t prog [$];
    int                  last_dest = 1; // most recent destination, for dependency chains

    cpu_isa_pkg::opcode_e alu_ops [14] = '{
        cpu_isa_pkg::op_add, cpu_isa_pkg::op_addi, cpu_isa_pkg::op_sub, cpu_isa_pkg::op_subi,
        cpu_isa_pkg::op_and, cpu_isa_pkg::op_or, cpu_isa_pkg::op_xor, cpu_isa_pkg::op_not,
        cpu_isa_pkg::op_shftr, cpu_isa_pkg::op_shftri, cpu_isa_pkg::op_shftl,
        cpu_isa_pkg::op_shftli, cpu_isa_pkg::op_mov_rs, cpu_isa_pkg::op_mov_l
    };

    function automatic cpu_isa_pkg::instr_t encode(input cpu_isa_pkg::opcode_e op,
                                                   input int rd, input int rs, input int rt,
                                                   input int lit);
        return {op, rd[4:0], rs[4:0], rt[4:0], lit[11:0]};
    endfunction

    // writes r1..r26 only, r27 to r29 stay fixed
    function automatic cpu_isa_pkg::instr_t random_alu();
        cpu_isa_pkg::opcode_e op;
        int dest, src, lit;
        op   = alu_ops[$urandom_range(0, 13)];
        dest = $urandom_range(1, 26);
        src  = ($urandom_range(0, 1) == 1) ? last_dest : $urandom_range(0, 31);
        lit  = $urandom_range(0, 4095);
        if (op == cpu_isa_pkg::op_shftri || op == cpu_isa_pkg::op_shftli)
            lit = lit % 64;
        if (op inside {cpu_isa_pkg::op_addi, cpu_isa_pkg::op_subi, cpu_isa_pkg::op_shftri,
                       cpu_isa_pkg::op_shftli, cpu_isa_pkg::op_mov_l} &&
            $urandom_range(0, 1) == 1)
            dest = last_dest; // rd is a source here too
        last_dest = dest;
        return encode(op, dest, src, $urandom_range(0, 31), lit);
    endfunction

    task automatic build_program();
        int k, kind, dest, target;
        prog.push_back(encode(cpu_isa_pkg::op_mov_l, 29, 0, 0, 'h002));
        prog.push_back(encode(cpu_isa_pkg::op_shftli, 29, 0, 0, 12)); // r29 = 0x2000
        prog.push_back(encode(cpu_isa_pkg::op_mov_l, 27, 0, 0, 'h040));
        prog.push_back(encode(cpu_isa_pkg::op_shftli, 27, 0, 0, 12)); // r27 = 0x40000
        for (int r = 1; r <= 26; r++)
            prog.push_back(encode(cpu_isa_pkg::op_mov_l, r, 0, 0, $urandom_range(0, 4095)));
        while (prog.size() < 290) begin
            kind = $urandom_range(0, 9);
            if (kind < 5) begin
                prog.push_back(random_alu());
            end else if (kind == 5) begin
                dest = $urandom_range(1, 26);
                prog.push_back(encode(cpu_isa_pkg::op_load, dest, 27, 0,
                                      8 * $urandom_range(0, 255)));
                last_dest = dest; // next alu op often uses it
            end else if (kind == 6) begin
                prog.push_back(encode(cpu_isa_pkg::op_store, 27,
                                      ($urandom_range(0, 1) == 1) ? last_dest :
                                      $urandom_range(0, 31), 0, 8 * $urandom_range(0, 255)));
            end else begin
                k      = $urandom_range(1, 3); // instructions jumped over
                kind   = $urandom_range(0, 4);
                target = 4 * (prog.size() + 3 + k);
                if (kind == 3) begin
                    prog.push_back(encode(cpu_isa_pkg::op_xor, 28, 28, 28, 0));
                    prog.push_back(encode(cpu_isa_pkg::op_addi, 28, 0, 0, 4 * (k + 1)));
                end else begin
                    prog.push_back(encode(cpu_isa_pkg::op_mov_rs, 28, 29, 0, 0));
                    prog.push_back(encode(cpu_isa_pkg::op_addi, 28, 0, 0, target));
                end
                case (kind)
                    0: prog.push_back(encode(cpu_isa_pkg::op_br, 28, 0, 0, 0));
                    1: prog.push_back(encode(cpu_isa_pkg::op_brnz, 28,
                                             $urandom_range(0, 31), 0, 0));
                    2: prog.push_back(encode(cpu_isa_pkg::op_brgt, 28, $urandom_range(0, 31),
                                             $urandom_range(0, 31), 0));
                    3: prog.push_back(encode(cpu_isa_pkg::op_brr_rd, 28, 0, 0, 0));
                    default: prog.push_back(encode(cpu_isa_pkg::op_brr_l, 0, 0, 0, 4 * (k + 1)));
                endcase
                repeat (k) prog.push_back(random_alu());
            end
        end
        prog.push_back(encode(cpu_isa_pkg::op_halt, 0, 0, 0, 0));
        foreach (prog[i])
            write_bytes(1'b0, cpu_isa_pkg::pc_reset_addr + 32'(4 * i), 64'(prog[i]), 4);
    endtask

    // one instruction per step, fills the expected write and store queues
    task automatic run_model();
        cpu_isa_pkg::word_t    regs [32];
        cpu_isa_pkg::word_t    rdv, rsv, rtv, res;
        cpu_isa_pkg::instr_t   iw;
        cpu_isa_pkg::opcode_e  op;
        cpu_isa_pkg::addr_t    pc, cur, ea, sx;
        cpu_isa_pkg::literal_t l;
        bit                    wr, done;
        int                    steps;
        foreach (regs[i])
            regs[i] = '0;
        regs[31] = cpu_isa_pkg::stack_reset_value;
        pc       = cpu_isa_pkg::pc_reset_addr;
        done     = 1'b0;
        steps    = 0;
        while (!done && steps < 4000) begin
            cur = pc;
            iw  = cpu_isa_pkg::instr_t'(read_bytes(1'b0, cur, 4));
            op  = cpu_isa_pkg::opcode_e'(iw[31:27]);
            rdv = regs[iw[26:22]];
            rsv = regs[iw[21:17]];
            rtv = regs[iw[16:12]];
            l   = iw[11:0];
            sx  = {{20{l[11]}}, l}; // address offsets are signed
            pc  = cur + 32'd4;
            wr  = 1'b1;
            res = '0;
            steps++;
            case (op)
                cpu_isa_pkg::op_add:    res = rsv + rtv;
                cpu_isa_pkg::op_addi:   res = rdv + {52'd0, l};
                cpu_isa_pkg::op_sub:    res = rsv - rtv;
                cpu_isa_pkg::op_subi:   res = rdv - {52'd0, l};
                cpu_isa_pkg::op_and:    res = rsv & rtv;
                cpu_isa_pkg::op_or:     res = rsv | rtv;
                cpu_isa_pkg::op_xor:    res = rsv ^ rtv;
                cpu_isa_pkg::op_not:    res = ~rsv;
                cpu_isa_pkg::op_shftr:  res = rsv >> rtv;
                cpu_isa_pkg::op_shftri: res = rdv >> l;
                cpu_isa_pkg::op_shftl:  res = rsv << rtv;
                cpu_isa_pkg::op_shftli: res = rdv << l;
                cpu_isa_pkg::op_mov_rs: res = rsv;
                cpu_isa_pkg::op_mov_l:  res = {rdv[63:12], l}; // upper bits kept
                cpu_isa_pkg::op_load:   res = read_bytes(1'b1, rsv[31:0] + sx, 8);
                cpu_isa_pkg::op_store: begin
                    wr = 1'b0;
                    ea = rdv[31:0] + sx;
                    exp_stores.push_back('{addr: ea, data: rsv});
                    write_bytes(1'b1, ea, rsv, 8);
                end
                cpu_isa_pkg::op_halt: begin
                    wr   = 1'b0;
                    done = 1'b1;
                end
                default: wr = 1'b0; // branches and unknown opcodes
            endcase
            if (op == cpu_isa_pkg::op_br || (op == cpu_isa_pkg::op_brnz && rsv != 0) ||
                (op == cpu_isa_pkg::op_brgt && $signed(rsv) > $signed(rtv)))
                pc = rdv[31:0]; // absolute target in rd
            else if (op == cpu_isa_pkg::op_brr_rd)
                pc = cur + rdv[31:0];
            else if (op == cpu_isa_pkg::op_brr_l)
                pc = cur + sx;
            if (wr) begin
                regs[iw[26:22]] = res;
                exp_writes.push_back('{dest: iw[26:22], data: res});
            end
        end
    endtask

`endif

//--- verification/cpu_tb.sv
module cpu_tb;

    typedef struct packed {
        cpu_isa_pkg::reg_idx_t dest;
        cpu_isa_pkg::word_t    data;
    } reg_write_t;

    typedef struct packed {
        cpu_isa_pkg::addr_t addr;
        cpu_isa_pkg::word_t data;
    } store_t;

    localparam int clk_period = 8;

    logic                  clk;
    logic                  reset;
    cpu_isa_pkg::instr_t   instr;
    cpu_isa_pkg::word_t    load_data;
    cpu_isa_pkg::addr_t    fetch_addr;
    cpu_isa_pkg::addr_t    data_addr;
    logic                  store_we;
    cpu_isa_pkg::word_t    store_data;
    logic                  retire_we;
    cpu_isa_pkg::reg_idx_t retire_dest;
    cpu_isa_pkg::word_t    retire_data;
    logic                  hlt;

    byte unsigned mem [cpu_isa_pkg::addr_t];    // program plus DUT data
    byte unsigned shadow [cpu_isa_pkg::addr_t]; // reference model data
    reg_write_t   exp_writes [$];               // in program order
    store_t       exp_stores [$];
    int           errors = 0;
    int           checks = 0;
    bit           halt_done = 1'b0; // hlt seen high once

    cpu_core i_dut (
        .clk, .reset, .instr, .load_data, .fetch_addr, .data_addr, .store_we,
        .store_data, .retire_we, .retire_dest, .retire_data, .hlt
    );

    // untouched bytes, mixes every address bit
    function automatic byte unsigned fill_byte(input cpu_isa_pkg::addr_t a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
    endfunction

    // little-endian, n bytes
    function automatic cpu_isa_pkg::word_t read_bytes(input bit model,
                                                      input cpu_isa_pkg::addr_t a, input int n);
        cpu_isa_pkg::word_t w;
        cpu_isa_pkg::addr_t b;
        w = '0;
        for (int i = n - 1; i >= 0; i--) begin
            b = a + 32'(i);
            w = w << 8;
            if (model && shadow.exists(b))
                w[7:0] = shadow[b];
            else if (!model && mem.exists(b))
                w[7:0] = mem[b];
            else
                w[7:0] = fill_byte(b);
        end
        return w;
    endfunction

    function automatic void write_bytes(input bit model, input cpu_isa_pkg::addr_t a,
                                        input cpu_isa_pkg::word_t d, input int n);
        for (int i = 0; i < n; i++) begin
            if (model)
                shadow[a + 32'(i)] = d[8*i +: 8];
            else
                mem[a + 32'(i)] = d[8*i +: 8];
        end
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, expected);
        end
    endtask

    // outputs while reset holds and right after
    task automatic check_idle();
        check_value("hlt", 64'(hlt), 64'd0);
        check_value("retire_we", 64'(retire_we), 64'd0);
        check_value("store_we", 64'(store_we), 64'd0);
        check_value("fetch_addr", 64'(fetch_addr), 64'(cpu_isa_pkg::pc_reset_addr));
    endtask

    task automatic report_summary();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
    endtask

    `include "cpu_model.svh"

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // instruction and load data follow the addresses of this cycle
    always @(posedge clk) begin
        #1;
        instr     = cpu_isa_pkg::instr_t'(read_bytes(1'b0, fetch_addr, 4));
        load_data = read_bytes(1'b0, data_addr, 8);
    end

    always @(negedge clk) begin : port_monitor
        reg_write_t w;
        store_t     s;
        if (!reset) begin
            if (retire_we) begin
                if (halt_done || exp_writes.size() == 0) begin
                    errors++;
                    $display("register write to r%0d that the model does not expect",
                             retire_dest);
                end else begin
                    w = exp_writes.pop_front();
                    check_value("retire_dest", 64'(retire_dest), 64'(w.dest));
                    check_value("retire_data", retire_data, w.data);
                end
            end
            if (store_we) begin
                if (halt_done || exp_stores.size() == 0) begin
                    errors++;
                    $display("store to address %h that the model does not expect", data_addr);
                end else begin
                    s = exp_stores.pop_front();
                    check_value("data_addr", 64'(data_addr), 64'(s.addr));
                    check_value("store_data", store_data, s.data);
                end
                write_bytes(1'b0, data_addr, store_data, 8); // lands before the next load
            end
            if (halt_done) begin
                check_value("hlt", 64'(hlt), 64'd1); // sticky
            end else if (hlt) begin
                halt_done = 1'b1;
                check_value("writes left at halt", 64'(exp_writes.size()), 64'd0);
            end
        end
    end

    initial begin : watchdog
        #1;
        #((prog.size() * 20 + 40) * clk_period); // 20 cycles per instruction plus reset
        errors++;
        $display("timeout, the core never raised hlt");
        report_summary();
        $finish;
    end

    initial begin
        reset     = 1'b1;
        instr     = '0;
        load_data = '0;
        void'($urandom(32'hd1af8cb4));
        build_program();
        run_model();
        repeat (8) begin
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_idle(); // first cycle out of reset
        wait (halt_done);
        repeat (20) @(negedge clk);
        check_value("pending writes", 64'(exp_writes.size()), 64'd0);
        check_value("pending stores", 64'(exp_stores.size()), 64'd0);
        report_summary();
        $finish;
    end

endmodule
